/* src/pipe_pkg.sv */
package pipe_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // data word or pc
  typedef logic [WORD_W-1:0] word_t;

  // architectural register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // r0 is hardwired to zero
  localparam reg_addr_t ZERO_REG = '0;

endpackage

/* src/isa_pkg.sv */
package isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [11:0] alu_op_t;
  typedef logic [4:0]  load_op_t;
  typedef logic [2:0]  store_op_t;
  typedef logic [3:0]  br_kind_t;

  // one-hot alu_op_t bit positions
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  // conditional kinds sit above BR_BEQ
  localparam br_kind_t BR_NONE = 4'd0;
  localparam br_kind_t BR_B    = 4'd1;
  localparam br_kind_t BR_BL   = 4'd2;
  localparam br_kind_t BR_JIRL = 4'd3;
  localparam br_kind_t BR_BEQ  = 4'd4;
  localparam br_kind_t BR_BNE  = 4'd5;
  localparam br_kind_t BR_BLT  = 4'd6;
  localparam br_kind_t BR_BGE  = 4'd7;
  localparam br_kind_t BR_BLTU = 4'd8;
  localparam br_kind_t BR_BGEU = 4'd9;

  // major opcode, inst[31:26]
  localparam logic [5:0] OP6_ALU       = 6'h00;
  localparam logic [5:0] OP6_LU12I     = 6'h05;
  localparam logic [5:0] OP6_PCADDU12I = 6'h07;
  localparam logic [5:0] OP6_MEM       = 6'h0a;
  localparam logic [5:0] OP6_JIRL      = 6'h13;
  localparam logic [5:0] OP6_B         = 6'h14;
  localparam logic [5:0] OP6_BL        = 6'h15;
  localparam logic [5:0] OP6_BEQ       = 6'h16;
  localparam logic [5:0] OP6_BNE       = 6'h17;
  localparam logic [5:0] OP6_BLT       = 6'h18;
  localparam logic [5:0] OP6_BGE       = 6'h19;
  localparam logic [5:0] OP6_BLTU      = 6'h1a;
  localparam logic [5:0] OP6_BGEU      = 6'h1b;

  // inst[25:22] and inst[21:20] selectors inside OP6_ALU
  localparam logic [3:0] OP4_3R     = 4'h0;
  localparam logic [3:0] OP4_SHIFTI = 4'h1;
  localparam logic [1:0] OP2_3R     = 2'h1;
  localparam logic [1:0] OP2_SHIFTI = 2'h0;

  localparam logic [4:0]  LINK_REG    = 5'd1;
  localparam logic [31:0] LINK_OFFSET = 32'd4;

endpackage

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
  import pipe_pkg::*;
  import isa_pkg::*;
(
  input  inst_t     inst,
  output reg_addr_t rj,
  output reg_addr_t rk,
  output reg_addr_t rd,
  output reg_addr_t rf_raddr2,
  output reg_addr_t dest,
  output word_t     imm,
  output alu_op_t   alu_op,
  output load_op_t  load_op,
  output store_op_t store_op,
  output br_kind_t  br_kind,
  output logic      src1_is_pc,
  output logic      src2_is_imm,
  output logic      uses_rj,
  output logic      uses_rkd,
  output logic      gr_we
);

  logic [5:0] op6;
  logic [3:0] op4;
  logic [1:0] op2;
  logic [4:0] op5;
  word_t      ui5;
  word_t      ui12;
  word_t      si12;
  word_t      si20;
  word_t      offs16;
  word_t      offs26;
  logic       is_3r;
  logic       is_pcadd;
  logic       is_cond;
  logic       is_link;
  logic       writes_rd;

  assign op6 = inst[31:26];
  assign op4 = inst[25:22];
  assign op2 = inst[21:20];
  assign op5 = inst[19:15];

  assign rd = inst[4:0];
  assign rj = inst[9:5];
  assign rk = inst[14:10];

  assign ui5    = {27'b0, inst[14:10]};
  assign ui12   = {20'b0, inst[21:10]};
  assign si12   = {{20{inst[21]}}, inst[21:10]};
  assign si20   = {inst[24:5], 12'b0};
  assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
  assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

  // jumps carry their branch offset in imm
  always_comb begin
    alu_op   = '0;
    load_op  = '0;
    store_op = '0;
    br_kind  = BR_NONE;
    imm      = '0;
    is_3r    = 1'b0;
    is_pcadd = 1'b0;
    case (op6)
      OP6_ALU: begin
        if (op4 == OP4_3R && op2 == OP2_3R) begin
          is_3r = 1'b1;
          case (op5)
            5'h00: alu_op[ALU_ADD] = 1'b1;
            5'h02: alu_op[ALU_SUB] = 1'b1;
            5'h04: alu_op[ALU_SLT] = 1'b1;
            5'h05: alu_op[ALU_SLTU] = 1'b1;
            5'h08: alu_op[ALU_NOR] = 1'b1;
            5'h09: alu_op[ALU_AND] = 1'b1;
            5'h0a: alu_op[ALU_OR] = 1'b1;
            5'h0b: alu_op[ALU_XOR] = 1'b1;
            5'h0e: alu_op[ALU_SLL] = 1'b1;
            5'h0f: alu_op[ALU_SRL] = 1'b1;
            5'h10: alu_op[ALU_SRA] = 1'b1;
            default: ;
          endcase
        end else if (op4 == OP4_SHIFTI && op2 == OP2_SHIFTI) begin
          imm = ui5;
          case (op5)
            5'h01: alu_op[ALU_SLL] = 1'b1;
            5'h09: alu_op[ALU_SRL] = 1'b1;
            5'h11: alu_op[ALU_SRA] = 1'b1;
            default: ;
          endcase
        end else begin
          // andi, ori, xori zero-extend
          imm = (op4[3:2] == 2'b11) ? ui12 : si12;
          case (op4)
            4'h8: alu_op[ALU_SLT] = 1'b1;
            4'h9: alu_op[ALU_SLTU] = 1'b1;
            4'ha: alu_op[ALU_ADD] = 1'b1;
            4'hd: alu_op[ALU_AND] = 1'b1;
            4'he: alu_op[ALU_OR] = 1'b1;
            4'hf: alu_op[ALU_XOR] = 1'b1;
            default: ;
          endcase
        end
      end
      OP6_LU12I: begin
        if (!inst[25]) begin
          alu_op[ALU_LUI] = 1'b1;
          imm = si20;
        end
      end
      OP6_PCADDU12I: begin
        if (!inst[25]) begin
          alu_op[ALU_ADD] = 1'b1;
          imm = si20;
          is_pcadd = 1'b1;
        end
      end
      OP6_MEM: begin
        case (op4)
          4'h0: load_op = 5'b00001;
          4'h1: load_op = 5'b00010;
          4'h2: load_op = 5'b00100;
          4'h8: load_op = 5'b01000;
          4'h9: load_op = 5'b10000;
          4'h4: store_op = 3'b001;
          4'h5: store_op = 3'b010;
          4'h6: store_op = 3'b100;
          default: ;
        endcase
        // address is rj + si12
        if (|{load_op, store_op}) begin
          alu_op[ALU_ADD] = 1'b1;
          imm = si12;
        end
      end
      OP6_JIRL: begin
        br_kind = BR_JIRL;
        alu_op[ALU_ADD] = 1'b1;
        imm = offs16;
      end
      OP6_B: begin
        br_kind = BR_B;
        imm = offs26;
      end
      OP6_BL: begin
        br_kind = BR_BL;
        alu_op[ALU_ADD] = 1'b1;
        imm = offs26;
      end
      OP6_BEQ: br_kind = BR_BEQ;
      OP6_BNE: br_kind = BR_BNE;
      OP6_BLT: br_kind = BR_BLT;
      OP6_BGE: br_kind = BR_BGE;
      OP6_BLTU: br_kind = BR_BLTU;
      OP6_BGEU: br_kind = BR_BGEU;
      default: ;
    endcase
    if (br_kind >= BR_BEQ) begin
      imm = offs16;
    end
  end

  assign is_cond = (br_kind >= BR_BEQ);
  assign is_link = (br_kind == BR_BL) || (br_kind == BR_JIRL);

  assign src1_is_pc  = is_pcadd || is_link;
  assign src2_is_imm = (|alu_op) && !is_3r;
  assign uses_rj  = ((|alu_op) && !alu_op[ALU_LUI] && !is_pcadd && br_kind != BR_BL) || is_cond;
  assign uses_rkd = ((|alu_op) && is_3r) || (|store_op) || is_cond;

  // stores and branches read rd through port 2
  assign rf_raddr2 = ((|store_op) || is_cond) ? rd : rk;

  assign writes_rd = (|alu_op) && !(|store_op);
  assign dest  = !writes_rd ? ZERO_REG : (br_kind == BR_BL) ? LINK_REG : rd;
  assign gr_we = writes_rd && (dest != ZERO_REG);

endmodule

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile
  import pipe_pkg::*;
(
  input  logic      clk,
  input  reg_addr_t raddr1,
  output word_t     rdata1,
  input  reg_addr_t raddr2,
  output word_t     rdata2,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (we && waddr != ZERO_REG) begin
      regs[waddr] <= wdata;
    end
  end

  // r0 entry is never written
  assign rdata1 = (raddr1 == ZERO_REG) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == ZERO_REG) ? '0 : regs[raddr2];

endmodule

/* src/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward
  import pipe_pkg::*;
(
  input  reg_addr_t rf_raddr1,
  input  reg_addr_t rf_raddr2,
  input  word_t     rf_rdata1,
  input  word_t     rf_rdata2,
  input  logic      uses_rj,
  input  logic      uses_rkd,
  input  logic      exe_we,
  input  reg_addr_t exe_dest,
  input  word_t     exe_result,
  input  logic      exe_is_load,
  input  logic      mem_we,
  input  reg_addr_t mem_dest,
  input  word_t     mem_result,
  input  logic      mem_is_load,
  input  logic      wb_we,
  input  reg_addr_t wb_dest,
  input  word_t     wb_data,
  output word_t     rj_value,
  output word_t     rkd_value,
  output logic      ready_go
);

  logic exe_hit1;
  logic mem_hit1;
  logic wb_hit1;
  logic exe_hit2;
  logic mem_hit2;
  logic wb_hit2;
  logic load_use;

  function automatic logic hit(logic we, reg_addr_t wdest, reg_addr_t raddr);
    return we && (wdest == raddr) && (raddr != ZERO_REG);
  endfunction

  assign exe_hit1 = hit(exe_we, exe_dest, rf_raddr1);
  assign mem_hit1 = hit(mem_we, mem_dest, rf_raddr1);
  assign wb_hit1  = hit(wb_we, wb_dest, rf_raddr1);
  assign exe_hit2 = hit(exe_we, exe_dest, rf_raddr2);
  assign mem_hit2 = hit(mem_we, mem_dest, rf_raddr2);
  assign wb_hit2  = hit(wb_we, wb_dest, rf_raddr2);

  // youngest writer wins
  assign rj_value  = exe_hit1 ? exe_result :
                     mem_hit1 ? mem_result :
                     wb_hit1  ? wb_data    : rf_rdata1;
  assign rkd_value = exe_hit2 ? exe_result :
                     mem_hit2 ? mem_result :
                     wb_hit2  ? wb_data    : rf_rdata2;

  // load data not yet available in exe or mem
  assign load_use = (exe_is_load && ((uses_rj && exe_hit1) || (uses_rkd && exe_hit2))) ||
                    (mem_is_load && ((uses_rj && mem_hit1) || (uses_rkd && mem_hit2)));

  assign ready_go = !load_use;

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
  import pipe_pkg::*;
  import isa_pkg::*;
(
  input  br_kind_t br_kind,
  input  word_t    pc,
  input  word_t    imm,
  input  word_t    rj_value,
  input  word_t    rkd_value,
  input  logic     valid,
  input  logic     ready_go,
  output logic     br_taken,
  output word_t    br_target
);

  logic [32:0] diff;
  logic        eq;
  logic        lt;
  logic        ltu;
  logic        cond;

  // rj - rkd, carry out clear means borrow
  assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;
  assign eq   = (rj_value == rkd_value);
  assign ltu  = !diff[32];
  assign lt   = (rj_value[31] != rkd_value[31]) ? rj_value[31] : diff[31];

  always_comb begin
    case (br_kind)
      BR_B, BR_BL, BR_JIRL: cond = 1'b1;
      BR_BEQ: cond = eq;
      BR_BNE: cond = !eq;
      BR_BLT: cond = lt;
      BR_BGE: cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign br_taken  = cond && valid && ready_go;
  assign br_target = ((br_kind == BR_JIRL) ? rj_value : pc) + imm;

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
  import pipe_pkg::*;
  import isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  word_t     in_pc,
  input  inst_t     in_inst,
  output logic      in_ready,
  output logic      out_valid,
  output word_t     out_pc,
  output alu_op_t   alu_op,
  output word_t     alu_src1,
  output word_t     alu_src2,
  output load_op_t  load_op,
  output store_op_t store_op,
  output word_t     rkd_value,
  output logic      gr_we,
  output reg_addr_t dest,
  input  logic      out_ready,
  input  logic      exe_we,
  input  reg_addr_t exe_dest,
  input  word_t     exe_result,
  input  logic      exe_is_load,
  input  logic      mem_we,
  input  reg_addr_t mem_dest,
  input  word_t     mem_result,
  input  logic      mem_is_load,
  input  logic      wb_we,
  input  reg_addr_t wb_dest,
  input  word_t     wb_data,
  output logic      br_taken,
  output word_t     br_target
);

  logic      valid;
  word_t     pc_q;
  inst_t     inst_q;
  reg_addr_t rj;
  reg_addr_t rf_raddr2;
  word_t     imm;
  word_t     src2_imm;
  br_kind_t  br_kind;
  logic      src1_is_pc;
  logic      src2_is_imm;
  logic      uses_rj;
  logic      uses_rkd;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  word_t     rj_value;
  logic      ready_go;

  assign in_ready  = !valid || (ready_go && out_ready);
  assign out_valid = valid && ready_go;

  // a taken branch drops whatever fetch offers next
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (br_taken) begin
      valid <= 1'b0;
    end else if (in_ready) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      pc_q   <= in_pc;
      inst_q <= in_inst;
    end
  end

  inst_decoder u_dec (
    .inst        (inst_q),
    .rj          (rj),
    .rk          (),
    .rd          (),
    .rf_raddr2   (rf_raddr2),
    .dest        (dest),
    .imm         (imm),
    .alu_op      (alu_op),
    .load_op     (load_op),
    .store_op    (store_op),
    .br_kind     (br_kind),
    .src1_is_pc  (src1_is_pc),
    .src2_is_imm (src2_is_imm),
    .uses_rj     (uses_rj),
    .uses_rkd    (uses_rkd),
    .gr_we       (gr_we)
  );

  regfile u_rf (
    .clk    (clk),
    .raddr1 (rj),
    .rdata1 (rf_rdata1),
    .raddr2 (rf_raddr2),
    .rdata2 (rf_rdata2),
    .we     (wb_we),
    .waddr  (wb_dest),
    .wdata  (wb_data)
  );

  operand_forward u_fwd (
    .rf_raddr1   (rj),
    .rf_raddr2   (rf_raddr2),
    .rf_rdata1   (rf_rdata1),
    .rf_rdata2   (rf_rdata2),
    .uses_rj     (uses_rj),
    .uses_rkd    (uses_rkd),
    .exe_we      (exe_we),
    .exe_dest    (exe_dest),
    .exe_result  (exe_result),
    .exe_is_load (exe_is_load),
    .mem_we      (mem_we),
    .mem_dest    (mem_dest),
    .mem_result  (mem_result),
    .mem_is_load (mem_is_load),
    .wb_we       (wb_we),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data),
    .rj_value    (rj_value),
    .rkd_value   (rkd_value),
    .ready_go    (ready_go)
  );

  // fire only when execute takes the branch, so back-pressure keeps it held
  branch_unit u_br (
    .br_kind   (br_kind),
    .pc        (pc_q),
    .imm       (imm),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .valid     (valid && out_ready),
    .ready_go  (ready_go),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

  // link instructions compute pc + 4
  assign src2_imm = (br_kind == BR_BL || br_kind == BR_JIRL) ? LINK_OFFSET : imm;

  assign out_pc   = pc_q;
  assign alu_src1 = src1_is_pc ? pc_q : rj_value;
  assign alu_src2 = src2_is_imm ? src2_imm : rkd_value;

endmodule

/* tests/decode_stage_sva.sv */
`timescale 1ns/1ps

module decode_stage_sva
  import pipe_pkg::*;
  import isa_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      valid,
  input logic      ready_go,
  input logic      out_valid,
  input logic      out_ready,
  input logic      br_taken,
  input word_t     out_pc,
  input alu_op_t   alu_op,
  input word_t     alu_src1,
  input word_t     alu_src2,
  input reg_addr_t dest,
  input logic      gr_we
);

  // a load-use stall keeps the instruction in place
  a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (valid && !ready_go) |=> (valid && $stable(out_pc)))
    else $error("stalled instruction was not held");

  a_taken_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    br_taken |-> out_valid)
    else $error("br_taken without out_valid");

  // held item must not move while execute is busy
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> ($stable(out_valid) && $stable(out_pc) &&
      $stable(alu_op) && $stable(alu_src1) && $stable(alu_src2) &&
      $stable(dest) && $stable(gr_we)))
    else $error("outputs changed under back-pressure");

  a_flush_after_taken: assert property (@(posedge clk) disable iff (!rst_n)
    br_taken |=> !valid)
    else $error("stage still valid after a taken branch");

endmodule

bind decode_stage decode_stage_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .valid     (valid),
  .ready_go  (ready_go),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .br_taken  (br_taken),
  .out_pc    (out_pc),
  .alu_op    (alu_op),
  .alu_src1  (alu_src1),
  .alu_src2  (alu_src2),
  .dest      (dest),
  .gr_we     (gr_we)
);

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
  import pipe_pkg::*;
  import isa_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  word_t     in_pc;
  inst_t     in_inst;
  logic      in_ready;
  logic      out_valid;
  word_t     out_pc;
  alu_op_t   alu_op;
  word_t     alu_src1;
  word_t     alu_src2;
  load_op_t  load_op;
  store_op_t store_op;
  word_t     rkd_value;
  logic      gr_we;
  reg_addr_t dest;
  logic      out_ready;
  logic      exe_we;
  reg_addr_t exe_dest;
  word_t     exe_result;
  logic      exe_is_load;
  logic      mem_we;
  reg_addr_t mem_dest;
  word_t     mem_result;
  logic      mem_is_load;
  logic      wb_we;
  reg_addr_t wb_dest;
  word_t     wb_data;
  logic      br_taken;
  word_t     br_target;

  integer seed = 32'hd902_4c1a;
  int     errors = 0;
  int     delivered = 0;
  word_t  model [32];
  word_t  pc_q [$];
  inst_t  inst_q [$];

  decode_stage dut (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_pc(in_pc), .in_inst(in_inst),
    .in_ready(in_ready), .out_valid(out_valid), .out_pc(out_pc), .alu_op(alu_op),
    .alu_src1(alu_src1), .alu_src2(alu_src2), .load_op(load_op), .store_op(store_op),
    .rkd_value(rkd_value), .gr_we(gr_we), .dest(dest), .out_ready(out_ready),
    .exe_we(exe_we), .exe_dest(exe_dest), .exe_result(exe_result),
    .exe_is_load(exe_is_load), .mem_we(mem_we), .mem_dest(mem_dest),
    .mem_result(mem_result), .mem_is_load(mem_is_load), .wb_we(wb_we),
    .wb_dest(wb_dest), .wb_data(wb_data), .br_taken(br_taken), .br_target(br_target)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (wb_we && wb_dest != 5'd0) begin
      model[wb_dest] <= wb_data;
    end
  end

  task automatic fail_run(input string msg);
    errors++;
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // youngest writer first, r0 never forwarded
  function automatic word_t fwd_value(input reg_addr_t a);
    if (a == 5'd0) return 32'd0;
    if (exe_we && exe_dest == a) return exe_result;
    if (mem_we && mem_dest == a) return mem_result;
    if (wb_we && wb_dest == a) return wb_data;
    return model[a];
  endfunction

  function automatic void ref_decode(
    input  word_t     pc,
    input  inst_t     inst,
    output alu_op_t   e_alu,
    output word_t     e_src1,
    output word_t     e_src2,
    output load_op_t  e_ld,
    output store_op_t e_st,
    output word_t     e_rkd,
    output logic      e_we,
    output reg_addr_t e_dest,
    output logic      e_taken,
    output word_t     e_target
  );
    logic [5:0] op6;
    logic [3:0] op4;
    logic [4:0] op5;
    word_t      imm;
    word_t      vj;
    word_t      vk;
    word_t      offs16;
    word_t      offs26;
    logic       is3r;
    logic       use_pc;
    logic       cond_br;
    logic       writes;
    op6 = inst[31:26];
    op4 = inst[25:22];
    op5 = inst[19:15];
    offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
    e_alu = '0;
    e_ld = '0;
    e_st = '0;
    imm = '0;
    is3r = 1'b0;
    use_pc = 1'b0;
    cond_br = 1'b0;
    e_taken = 1'b0;
    e_target = '0;
    e_dest = inst[4:0];
    vj = fwd_value(inst[9:5]);
    // bit order: add sub slt sltu and nor or xor sll srl sra lui
    case (op6)
      6'h00: begin
        if (op4 == 4'h0 && inst[21:20] == 2'h1) begin
          is3r = 1'b1;
          case (op5)
            5'h00: e_alu[0] = 1'b1;
            5'h02: e_alu[1] = 1'b1;
            5'h04: e_alu[2] = 1'b1;
            5'h05: e_alu[3] = 1'b1;
            5'h08: e_alu[5] = 1'b1;
            5'h09: e_alu[4] = 1'b1;
            5'h0a: e_alu[6] = 1'b1;
            5'h0b: e_alu[7] = 1'b1;
            5'h0e: e_alu[8] = 1'b1;
            5'h0f: e_alu[9] = 1'b1;
            5'h10: e_alu[10] = 1'b1;
            default: ;
          endcase
        end else if (op4 == 4'h1 && inst[21:20] == 2'h0) begin
          imm = {27'd0, inst[14:10]};
          if (op5 == 5'h01) e_alu[8] = 1'b1;
          if (op5 == 5'h09) e_alu[9] = 1'b1;
          if (op5 == 5'h11) e_alu[10] = 1'b1;
        end else begin
          imm = (op4 >= 4'hd) ? {20'd0, inst[21:10]} : {{20{inst[21]}}, inst[21:10]};
          case (op4)
            4'h8: e_alu[2] = 1'b1;
            4'h9: e_alu[3] = 1'b1;
            4'ha: e_alu[0] = 1'b1;
            4'hd: e_alu[4] = 1'b1;
            4'he: e_alu[6] = 1'b1;
            4'hf: e_alu[7] = 1'b1;
            default: ;
          endcase
        end
      end
      6'h05: begin
        if (!inst[25]) begin
          e_alu[11] = 1'b1;
          imm = {inst[24:5], 12'd0};
        end
      end
      6'h07: begin
        if (!inst[25]) begin
          e_alu[0] = 1'b1;
          imm = {inst[24:5], 12'd0};
          use_pc = 1'b1;
        end
      end
      6'h0a: begin
        case (op4)
          4'h0: e_ld[0] = 1'b1;
          4'h1: e_ld[1] = 1'b1;
          4'h2: e_ld[2] = 1'b1;
          4'h8: e_ld[3] = 1'b1;
          4'h9: e_ld[4] = 1'b1;
          4'h4: e_st[0] = 1'b1;
          4'h5: e_st[1] = 1'b1;
          4'h6: e_st[2] = 1'b1;
          default: ;
        endcase
        if (e_ld != 0 || e_st != 0) begin
          e_alu[0] = 1'b1;
          imm = {{20{inst[21]}}, inst[21:10]};
        end
      end
      6'h13: begin
        e_alu[0] = 1'b1;
        imm = 32'd4;
        use_pc = 1'b1;
        e_taken = 1'b1;
        e_target = vj + offs16;
      end
      6'h14: begin
        e_taken = 1'b1;
        e_target = pc + offs26;
      end
      6'h15: begin
        e_alu[0] = 1'b1;
        imm = 32'd4;
        use_pc = 1'b1;
        e_dest = 5'd1;
        e_taken = 1'b1;
        e_target = pc + offs26;
      end
      6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: cond_br = 1'b1;
      default: ;
    endcase
    vk = fwd_value((e_st != 0 || cond_br) ? inst[4:0] : inst[14:10]);
    if (cond_br) begin
      e_target = pc + offs16;
      case (op6)
        6'h16: e_taken = (vj == vk);
        6'h17: e_taken = (vj != vk);
        6'h18: e_taken = ($signed(vj) < $signed(vk));
        6'h19: e_taken = !($signed(vj) < $signed(vk));
        6'h1a: e_taken = (vj < vk);
        default: e_taken = !(vj < vk);
      endcase
    end
    writes = (e_alu != 0) && (e_st == 0);
    if (!writes) e_dest = 5'd0;
    e_we = writes && (e_dest != 5'd0);
    e_src1 = use_pc ? pc : vj;
    e_src2 = ((e_alu != 0) && !is3r) ? imm : vk;
    e_rkd = vk;
  endfunction

  // compares every valid output against the pending instruction
  always @(posedge clk) begin
    alu_op_t   e_alu;
    word_t     e_src1;
    word_t     e_src2;
    load_op_t  e_ld;
    store_op_t e_st;
    word_t     e_rkd;
    logic      e_we;
    reg_addr_t e_dest;
    logic      e_taken;
    word_t     e_target;
    if (rst_n) begin
      if (out_valid) begin
        if (pc_q.size() == 0) fail_run("output valid with no instruction pending");
        ref_decode(pc_q[0], inst_q[0], e_alu, e_src1, e_src2, e_ld, e_st, e_rkd,
                   e_we, e_dest, e_taken, e_target);
        check("out_pc", out_pc, pc_q[0]);
        check("alu_op", 32'(alu_op), 32'(e_alu));
        check("alu_src1", alu_src1, e_src1);
        check("alu_src2", alu_src2, e_src2);
        check("load_op", 32'(load_op), 32'(e_ld));
        check("store_op", 32'(store_op), 32'(e_st));
        check("rkd_value", rkd_value, e_rkd);
        check("gr_we", 32'(gr_we), 32'(e_we));
        check("dest", 32'(dest), 32'(e_dest));
        check("br_taken", 32'(br_taken), 32'(e_taken && out_ready));
        if (e_taken && out_ready) check("br_target", br_target, e_target);
        if (out_ready) begin
          void'(pc_q.pop_front());
          void'(inst_q.pop_front());
          delivered++;
        end
      end else begin
        check("br_taken", 32'(br_taken), 32'd0);
      end
      if (in_valid && in_ready && !br_taken) begin
        pc_q.push_back(in_pc);
        inst_q.push_back(in_inst);
      end
    end
  end

  // leaves in_valid high after the accepting edge
  task automatic offer(input word_t pc, input inst_t inst);
    int n;
    n = 0;
    @(negedge clk);
    in_valid = 1'b1;
    in_pc = pc;
    in_inst = inst;
    @(posedge clk);
    while (!in_ready) begin
      n++;
      if (n > TIMEOUT) fail_run("timeout waiting for in_ready");
      @(posedge clk);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    in_valid = 1'b0;
    while (pc_q.size() != 0) begin
      n++;
      if (n > TIMEOUT) fail_run("timeout waiting for the stage to drain");
      @(negedge clk);
    end
  endtask

  task automatic wait_out();
    int n;
    n = 0;
    @(posedge clk);
    while (!out_valid) begin
      n++;
      if (n > TIMEOUT) fail_run("timeout waiting for out_valid");
      @(posedge clk);
    end
  endtask

  task automatic clear_fwd();
    exe_we = 1'b0;
    exe_dest = '0;
    exe_result = '0;
    exe_is_load = 1'b0;
    mem_we = 1'b0;
    mem_dest = '0;
    mem_result = '0;
    mem_is_load = 1'b0;
    wb_we = 1'b0;
    wb_dest = '0;
    wb_data = '0;
  endtask

  function automatic inst_t gen_alu_mem();
    logic [31:0] r;
    int          g;
    int          k;
    inst_t       i;
    r = $random(seed);
    g = $unsigned($random(seed)) % 7;
    k = $unsigned($random(seed)) % 11;
    case (g)
      0: i = {6'h00, 4'h0, 2'h1, 5'(k == 0 ? 0 : k == 1 ? 2 : k == 2 ? 4 : k == 3 ? 5 :
              k == 4 ? 8 : k == 5 ? 9 : k == 6 ? 10 : k == 7 ? 11 : k == 8 ? 14 :
              k == 9 ? 15 : 16), r[14:0]};
      1: i = {6'h00, 4'h1, 2'h0, 5'((k % 3) * 8 + 1), r[14:0]};
      2: i = {6'h00, 4'((k % 6) < 3 ? 8 + (k % 6) : 10 + (k % 6)), r[21:0]};
      3: i = {6'h05, 1'b0, r[24:0]};
      4: i = {6'h07, 1'b0, r[24:0]};
      5: i = {6'h0a, 4'(k % 8 < 3 ? k % 8 : k % 8 < 5 ? 5 + k % 8 : k % 8 - 1), r[21:0]};
      default: i = r;
    endcase
    return i;
  endfunction

  // sources limited to r0..r7, which hold the edge values
  function automatic inst_t gen_branch();
    logic [31:0] r;
    int          k;
    r = $random(seed);
    k = $unsigned($random(seed)) % 9;
    return {6'(6'h13 + k), r[25:10], 2'b0, r[7:5], 2'b0, r[2:0]};
  endfunction

  initial begin
    word_t pc;
    int    hold;
    int    d0;
    inst_t bp_inst;
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_pc = '0;
    in_inst = '0;
    out_ready = 1'b1;
    clear_fwd();
    model[0] = '0;
    @(negedge clk);
    check("out_valid", 32'(out_valid), 32'd0);
    check("br_taken", 32'(br_taken), 32'd0);
    @(negedge clk);
    rst_n = 1'b1;

    for (int r = 1; r < 32; r++) begin
      wb_we = 1'b1;
      wb_dest = 5'(r);
      wb_data = (r == 1 || r == 5) ? 32'h8000_0000 : (r == 2) ? 32'h7fff_ffff :
                (r == 3) ? 32'hffff_ffff : (r == 4) ? 32'd1 : (r == 6) ? 32'd0 : $random(seed);
      @(negedge clk);
    end
    clear_fwd();

    for (int t = 0; t < 150; t++) begin
      offer($random(seed) & 32'hffff_fffc, gen_alu_mem());
      drain();
    end

    // forwarding priority on r7
    exe_we = 1'b1;
    exe_dest = 5'd7;
    exe_result = 32'h1111_aaaa;
    mem_we = 1'b1;
    mem_dest = 5'd7;
    mem_result = 32'h2222_bbbb;
    wb_we = 1'b1;
    wb_dest = 5'd7;
    wb_data = 32'h3333_cccc;
    for (int s = 0; s < 3; s++) begin
      offer(32'h100 + 32'(s * 4), {6'h00, 4'h0, 2'h1, 5'h00, 5'd7, 5'd7, 5'd3});
      wait_out();
      check("alu_src1", alu_src1, s == 0 ? 32'h1111_aaaa : s == 1 ? 32'h2222_bbbb
                                         : 32'h3333_cccc);
      drain();
      if (s == 0) exe_we = 1'b0;
      if (s == 1) mem_we = 1'b0;
    end
    exe_we = 1'b1;
    exe_dest = 5'd0;
    offer(32'h200, {6'h00, 4'h0, 2'h1, 5'h00, 5'd0, 5'd0, 5'd3});
    wait_out();
    check("alu_src1", alu_src1, 32'd0);
    drain();
    clear_fwd();

    // load-use stall from execute, then from memory
    for (int s = 0; s < 2; s++) begin
      if (s == 0) begin
        exe_we = 1'b1;
        exe_dest = 5'd5;
        exe_is_load = 1'b1;
      end else begin
        mem_we = 1'b1;
        mem_dest = 5'd5;
        mem_is_load = 1'b1;
      end
      offer(32'h300, s == 0 ? {6'h00, 4'h0, 2'h1, 5'h00, 5'd6, 5'd5, 5'd4}
                            : {6'h16, 16'h0010, 5'd5, 5'd5});
      hold = 2 + $unsigned($random(seed)) % 5;
      for (int c = 0; c < hold; c++) begin
        @(posedge clk);
        check("out_valid", 32'(out_valid), 32'd0);
        check("br_taken", 32'(br_taken), 32'd0);
      end
      @(negedge clk);
      clear_fwd();
      drain();
    end

    for (int t = 0; t < 60; t++) begin
      pc = $random(seed) & 32'hffff_fffc;
      offer(pc, gen_branch());
      offer(pc + 32'd4, {6'h00, 4'ha, 12'd0, 5'd0, 5'd0});
      drain();
    end

    // back-pressure with a second instruction waiting
    for (int t = 0; t < 10; t++) begin
      d0 = delivered;
      @(negedge clk);
      out_ready = 1'b0;
      bp_inst = gen_alu_mem();
      // a taken branch would flush the waiting instruction
      if (bp_inst[31:26] >= 6'h13 && bp_inst[31:26] <= 6'h1b) begin
        bp_inst[31:26] = 6'h00;
      end
      offer(32'h400, bp_inst);
      @(negedge clk);
      in_pc = 32'h404;
      in_inst = {6'h00, 4'ha, 12'h005, 5'd2, 5'd9};
      hold = 1 + $unsigned($random(seed)) % 8;
      for (int c = 0; c < hold; c++) begin
        @(posedge clk);
        check("in_ready", 32'(in_ready), 32'd0);
      end
      @(negedge clk);
      out_ready = 1'b1;
      @(posedge clk);
      drain();
      check("delivered", 32'(delivered - d0), 32'd2);
    end

    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
src/pipe_pkg.sv
src/isa_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/decode_stage.sv
tests/decode_stage_sva.sv
tests/tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_decode_stage
FLIST     := flist.f
FLAGS     := --binary --timing --assert -j 0
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)

run: build
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
